// ==== verilog.f ====
common/card_rd_pkg.sv
design/rd_arbiter.sv
design/mux_fifo.sv
card_mem/card_mem_reader.sv
design/axis_user_rd_assign.sv
design/card_rd_top.sv
verif/card_rd_assert.sv
verif/tb_card_rd.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the card read testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_card_rd -f verilog.f -o tb_card_rd \
  && ./obj_dir/tb_card_rd +verilator+error+limit+100 2>&1 | tee sim.log
grep -q "ALL TESTS PASSED" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== verif/tb_card_rd.sv ====
// --------------------
// Directed testbench for card_rd_top
// Memory is filled with LFSR words, a local copy gives the expected data
// Beats are sampled on the falling edge, inputs change on the rising edge
// Grant order in each test follows the round-robin rule from the pointer left
// by the test before, so tests must run in this order
// --------------------
`timescale 1ns/1ps

module tb_card_rd import card_rd_pkg::*; ();

  localparam int N_REQ      = 4;
  localparam int FIFO_DEPTH = 4;

  logic             aclk = 1'b0;
  logic             aresetn;
  logic [N_REQ-1:0] req_valid;
  logic [N_REQ-1:0] req_ready;
  addr_t [N_REQ-1:0] req_addr;
  len_t  [N_REQ-1:0] req_len;
  logic             mem_wr_en;
  addr_t            mem_wr_addr;
  data_t            mem_wr_data;
  logic             m_tvalid;
  logic             m_tready;
  data_t            m_tdata;
  logic             m_tlast;
  pid_t             m_tid;

  // Reference copy of card memory
  data_t model_mem [2**ADDR_BITS];

  // Requests not yet granted, per requester
  addr_t pend_addr [N_REQ][$];
  len_t  pend_len  [N_REQ][$];

  // Expected and observed results
  data_t exp_data [$];
  pid_t  exp_pid  [$];
  logic  exp_last [$];
  pid_t  exp_grant [$];
  data_t got_data [$];
  pid_t  got_pid  [$];
  logic  got_last [$];
  pid_t  grant_q  [$];
  int    got_base = 0;

  logic [31:0] lfsr_q = 32'h6535a25e;
  bit          stream_done;
  int          err_cnt = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  card_rd_top #(
    .N_REQ      (N_REQ),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dut (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_addr    (req_addr),
    .req_len     (req_len),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_addr (mem_wr_addr),
    .mem_wr_data (mem_wr_data),
    .m_tvalid    (m_tvalid),
    .m_tready    (m_tready),
    .m_tdata     (m_tdata),
    .m_tlast     (m_tlast),
    .m_tid       (m_tid)
  );

  // 40 ns period
  always #20 aclk = ~aclk;

  // Beat recorder, a beat seen here moves on the next rising edge
  always @(negedge aclk) begin
    if (aresetn && m_tvalid && m_tready) begin
      got_data.push_back(m_tdata);
      got_pid.push_back(m_tid);
      got_last.push_back(m_tlast);
    end
  end

  // --------------------
  // Helpers
  // --------------------

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s got 0x%0h exp 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_pid(input string name, input pid_t got, input pid_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s got 0x%0h exp 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s got 0x%0h exp 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s got 0x%0h exp 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_ready(input string name, input logic [N_REQ-1:0] got,
                             input logic [N_REQ-1:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s got 0x%0h exp 0x%0h", name, got, exp);
    end
  endtask

  // Whole array through the write strobe
  task automatic load_mem();
    int    a;
    int    b;
    data_t w;
    for (a = 0; a < 2**ADDR_BITS; a++) begin
      w = '0;
      for (b = 0; b < DATA_BITS; b++) begin
        w = {w[DATA_BITS-2:0], lfsr_step()};
      end
      model_mem[a] = w;
      @(posedge aclk);
      mem_wr_en   <= 1'b1;
      mem_wr_addr <= addr_t'(a);
      mem_wr_data <= w;
    end
    @(posedge aclk);
    mem_wr_en <= 1'b0;
  endtask

  task automatic queue_read(input int idx, input addr_t addr, input len_t len);
    pend_addr[idx].push_back(addr);
    pend_len[idx].push_back(len);
  endtask

  // Beats of one read, addresses wrap like the card array
  task automatic expect_read(input pid_t pid, input addr_t addr, input len_t len);
    int    k;
    addr_t a;
    a = addr;
    exp_grant.push_back(pid);
    for (k = 0; k <= int'(len); k++) begin
      exp_data.push_back(model_mem[a]);
      exp_pid.push_back(pid);
      exp_last.push_back(k == int'(len));
      a = a + 1'b1;
    end
  endtask

  // Raise valid for every idle requester with work queued
  task automatic start_reqs();
    int i;
    @(posedge aclk);
    for (i = 0; i < N_REQ; i++) begin
      if (pend_addr[i].size() > 0 && !req_valid[i]) begin
        req_valid[i] <= 1'b1;
        req_addr[i]  <= pend_addr[i][0];
        req_len[i]   <= pend_len[i][0];
      end
    end
  endtask

  // Watch grants, then load the next queued request or drop valid
  task automatic run_grants(input int want, input int limit, output int got);
    int               i;
    int               cycles;
    logic [N_REQ-1:0] hit;
    got = 0;
    cycles = 0;
    while (got < want && cycles < limit) begin
      @(negedge aclk);
      cycles++;
      hit = req_valid & req_ready;
      for (i = 0; i < N_REQ; i++) begin
        if (hit[i]) begin
          grant_q.push_back(pid_t'(i));
          got++;
        end
      end
      @(posedge aclk);
      for (i = 0; i < N_REQ; i++) begin
        if (hit[i]) begin
          void'(pend_addr[i].pop_front());
          void'(pend_len[i].pop_front());
          if (pend_addr[i].size() > 0) begin
            req_addr[i] <= pend_addr[i][0];
            req_len[i]  <= pend_len[i][0];
          end else begin
            req_valid[i] <= 1'b0;
          end
        end
      end
    end
  endtask

  task automatic grants_or_timeout(input int want, input int limit);
    int got;
    run_grants(want, limit, got);
    if (got != want) begin
      err_cnt++;
      $display("timeout: only %0d of %0d requests were granted", got, want);
    end
  endtask

  task automatic wait_beats(input int limit);
    int cycles;
    cycles = 0;
    while ((got_data.size() - got_base) < exp_data.size() && cycles < limit) begin
      @(posedge aclk);
      cycles++;
    end
    if ((got_data.size() - got_base) < exp_data.size()) begin
      err_cnt++;
      $display("timeout: stream stopped after %0d of %0d beats",
               got_data.size() - got_base, exp_data.size());
    end
  endtask

  // Beats and grant order against the expected lists, then start fresh
  task automatic compare_stream();
    int k;
    int n_got;
    n_got = got_data.size() - got_base;
    if (n_got != exp_data.size()) begin
      err_cnt++;
      $display("wrong beat count: %0d beats seen, %0d expected", n_got, exp_data.size());
    end
    for (k = 0; k < exp_data.size() && k < n_got; k++) begin
      check_data($sformatf("m_tdata beat %0d", k), got_data[got_base + k], exp_data[k]);
      check_pid($sformatf("m_tid beat %0d", k), got_pid[got_base + k], exp_pid[k]);
      check_last($sformatf("m_tlast beat %0d", k), got_last[got_base + k], exp_last[k]);
    end
    if (grant_q.size() != exp_grant.size()) begin
      err_cnt++;
      $display("wrong grant count: %0d grants seen, %0d expected",
               grant_q.size(), exp_grant.size());
    end
    for (k = 0; k < exp_grant.size() && k < grant_q.size(); k++) begin
      check_pid($sformatf("grant index %0d", k), grant_q[k], exp_grant[k]);
    end
    got_base = got_data.size();
    exp_data.delete();
    exp_pid.delete();
    exp_last.delete();
    exp_grant.delete();
    grant_q.delete();
  endtask

  task automatic report_test(input string name, input int e0);
    tests_run++;
    if (err_cnt == e0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, err_cnt - e0);
    end
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic test_single_read();
    int e0;
    e0 = err_cnt;
    @(negedge aclk);
    check_ready("req_ready", req_ready, '0);
    check_flag("m_tvalid", m_tvalid, 1'b0);
    queue_read(2, 8'h10, 4'd3);
    expect_read(2'd2, 8'h10, 4'd3);
    start_reqs();
    grants_or_timeout(1, 50);
    wait_beats(200);
    compare_stream();
    report_test("single_read", e0);
  endtask

  // Pointer sits at 3 after the grant to 2
  task automatic test_back_to_back();
    int e0;
    e0 = err_cnt;
    queue_read(3, 8'h40, 4'd2);
    expect_read(2'd3, 8'h40, 4'd2);
    start_reqs();
    grants_or_timeout(1, 50);
    queue_read(1, 8'h22, 4'd5);
    expect_read(2'd1, 8'h22, 4'd5);
    start_reqs();
    grants_or_timeout(1, 100);
    wait_beats(300);
    compare_stream();
    report_test("back_to_back", e0);
  endtask

  // Grant to 0 moves the pointer to 1, so the order is 1 2 3 0
  task automatic test_round_robin();
    int e0;
    e0 = err_cnt;
    queue_read(0, 8'h80, 4'd1);
    expect_read(2'd0, 8'h80, 4'd1);
    start_reqs();
    grants_or_timeout(1, 50);
    queue_read(0, 8'h90, 4'd2);
    queue_read(1, 8'hA0, 4'd3);
    queue_read(2, 8'hB0, 4'd0);
    // Runs past the top of the array
    queue_read(3, 8'hFE, 4'd3);
    expect_read(2'd1, 8'hA0, 4'd3);
    expect_read(2'd2, 8'hB0, 4'd0);
    expect_read(2'd3, 8'hFE, 4'd3);
    expect_read(2'd0, 8'h90, 4'd2);
    start_reqs();
    grants_or_timeout(4, 400);
    wait_beats(400);
    compare_stream();
    report_test("round_robin", e0);
  endtask

  task automatic test_random_ready();
    int e0;
    e0 = err_cnt;
    queue_read(3, 8'h30, 4'd15);
    expect_read(2'd3, 8'h30, 4'd15);
    start_reqs();
    grants_or_timeout(1, 50);
    stream_done = 1'b0;
    fork
      begin
        wait_beats(800);
        stream_done = 1'b1;
      end
      begin
        // One LFSR bit per cycle of m_tready
        while (!stream_done) begin
          @(posedge aclk);
          m_tready <= lfsr_step();
        end
      end
    join
    @(posedge aclk);
    m_tready <= 1'b1;
    compare_stream();
    report_test("random_ready", e0);
  endtask

  // Six reads against a stalled stream, pointer starts at 0
  task automatic test_fifo_stall();
    int e0;
    int got;
    e0 = err_cnt;
    @(posedge aclk);
    m_tready <= 1'b0;
    queue_read(0, 8'h50, 4'd2);
    queue_read(1, 8'h60, 4'd1);
    queue_read(2, 8'h70, 4'd3);
    queue_read(3, 8'hC0, 4'd0);
    queue_read(0, 8'hD0, 4'd2);
    queue_read(1, 8'hE0, 4'd1);
    expect_read(2'd0, 8'h50, 4'd2);
    expect_read(2'd1, 8'h60, 4'd1);
    expect_read(2'd2, 8'h70, 4'd3);
    expect_read(2'd3, 8'hC0, 4'd0);
    expect_read(2'd0, 8'hD0, 4'd2);
    expect_read(2'd1, 8'hE0, 4'd1);
    start_reqs();
    // Reader holds the first command, nothing else may get through
    run_grants(6, 40, got);
    if (got != 1) begin
      err_cnt++;
      $display("grants did not stop while m_tready was low: %0d grants", got);
    end
    @(negedge aclk);
    check_ready("req_ready", req_ready, '0);
    @(posedge aclk);
    m_tready <= 1'b1;
    grants_or_timeout(6 - got, 400);
    wait_beats(400);
    compare_stream();
    report_test("fifo_stall", e0);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    aresetn     <= 1'b0;
    req_valid   <= '0;
    req_addr    <= '0;
    req_len     <= '0;
    mem_wr_en   <= 1'b0;
    mem_wr_addr <= '0;
    mem_wr_data <= '0;
    m_tready    <= 1'b1;
    repeat (16) @(posedge aclk);
    aresetn <= 1'b1;
    load_mem();
    test_single_read();
    test_back_to_back();
    test_round_robin();
    test_random_ready();
    test_fifo_stall();
    $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, err_cnt, u_dut.u_chk.fail_cnt);
    if (err_cnt == 0 && u_dut.u_chk.fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/card_rd_assert.sv ====
// --------------------
// Stream and grant rules for card_rd_top, attached with bind
// Hold rule covers the user stream only, not the reader side
// tlast rule reads the assigner's beat counter directly
// --------------------
`timescale 1ns/1ps

module card_rd_assert import card_rd_pkg::*; #(
  parameter int N_REQ = 4
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic [N_REQ-1:0] req_ready,
  input  logic             m_tvalid,
  input  logic             m_tready,
  input  data_t            m_tdata,
  input  logic             m_tlast,
  input  len_t             asg_cnt
);

  // Failures seen so far, read by the testbench summary
  int fail_cnt = 0;

  // Stalled beat keeps its data
  a_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata)))
    else begin
      $error("m_tdata changed while m_tvalid was high and m_tready low");
      fail_cnt++;
    end

  // Never more than one grant
  a_grant: assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0(req_ready))
    else begin
      $error("more than one req_ready bit high");
      fail_cnt++;
    end

  // Last beat lines up with the queued length
  a_last: assert property (@(posedge aclk) disable iff (!aresetn)
    m_tvalid |-> (m_tlast == (asg_cnt == '0)))
    else begin
      $error("m_tlast does not match the assigner beat count");
      fail_cnt++;
    end

endmodule

bind card_rd_top card_rd_assert #(
  .N_REQ (N_REQ)
) u_chk (
  .aclk      (aclk),
  .aresetn   (aresetn),
  .req_ready (req_ready),
  .m_tvalid  (m_tvalid),
  .m_tready  (m_tready),
  .m_tdata   (m_tdata),
  .m_tlast   (m_tlast),
  .asg_cnt   (u_assign.cnt_q)
);

// ==== design/card_rd_top.sv ====
// --------------------
// Read side of the shared card memory
// Arbiter, metadata FIFO, reader and id assigner in one pipeline
// Each transfer ends on m_tlast with m_tvalid and m_tready high
// Memory is loaded through the write strobe only
// --------------------
`timescale 1ns/1ps

module card_rd_top import card_rd_pkg::*; #(
  parameter int N_REQ      = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  logic              aclk,
  input  logic              aresetn,

  // Requesters, one slot per index
  input  logic  [N_REQ-1:0] req_valid,
  output logic  [N_REQ-1:0] req_ready,
  input  addr_t [N_REQ-1:0] req_addr,
  input  len_t  [N_REQ-1:0] req_len,

  // Memory load strobe
  input  logic              mem_wr_en,
  input  addr_t             mem_wr_addr,
  input  data_t             mem_wr_data,

  // Tagged user stream
  output logic              m_tvalid,
  input  logic              m_tready,
  output data_t             m_tdata,
  output logic              m_tlast,
  output pid_t              m_tid
);

  // Arbiter to reader
  logic  cmd_valid;
  logic  cmd_ready;
  addr_t cmd_addr;
  len_t  cmd_len;

  // Arbiter to FIFO
  logic  meta_push;
  pid_t  meta_pid;
  len_t  meta_len;
  logic  meta_full;

  // FIFO to assigner
  logic  mux_valid;
  logic  mux_ready;
  pid_t  mux_pid;
  len_t  mux_len;

  // Reader to assigner
  logic  rd_tvalid;
  logic  rd_tready;
  data_t rd_tdata;
  logic  rd_tlast;

  rd_arbiter #(
    .N_REQ (N_REQ)
  ) u_arb (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_addr  (req_addr),
    .req_len   (req_len),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_addr  (cmd_addr),
    .cmd_len   (cmd_len),
    .meta_push (meta_push),
    .meta_pid  (meta_pid),
    .meta_len  (meta_len),
    .meta_full (meta_full)
  );

  mux_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push      (meta_push),
    .push_pid  (meta_pid),
    .push_len  (meta_len),
    .full      (meta_full),
    .out_valid (mux_valid),
    .out_ready (mux_ready),
    .out_pid   (mux_pid),
    .out_len   (mux_len)
  );

  card_mem_reader u_reader (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_addr (mem_wr_addr),
    .mem_wr_data (mem_wr_data),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .cmd_addr    (cmd_addr),
    .cmd_len     (cmd_len),
    .m_tvalid    (rd_tvalid),
    .m_tready    (rd_tready),
    .m_tdata     (rd_tdata),
    .m_tlast     (rd_tlast)
  );

  axis_user_rd_assign u_assign (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .meta_valid (mux_valid),
    .meta_ready (mux_ready),
    .meta_pid   (mux_pid),
    .meta_len   (mux_len),
    .s_tvalid   (rd_tvalid),
    .s_tready   (rd_tready),
    .s_tdata    (rd_tdata),
    .s_tlast    (rd_tlast),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .m_tdata    (m_tdata),
    .m_tlast    (m_tlast),
    .m_tid      (m_tid)
  );

endmodule

// ==== design/axis_user_rd_assign.sv ====
// --------------------
// Tags the card read stream with the owning process id
// Transfer end comes from the queued length, s_tlast only passes through
// Needs one idle cycle to load the first entry
// Reloads on the last beat so back-to-back transfers lose no cycle
// --------------------
`timescale 1ns/1ps

module axis_user_rd_assign import card_rd_pkg::*; (
  input  logic  aclk,
  input  logic  aresetn,

  // Metadata from the mux FIFO
  input  logic  meta_valid,
  output logic  meta_ready,
  input  pid_t  meta_pid,
  input  len_t  meta_len,

  // Reader stream
  input  logic  s_tvalid,
  output logic  s_tready,
  input  data_t s_tdata,
  input  logic  s_tlast,

  // Tagged user stream
  output logic  m_tvalid,
  input  logic  m_tready,
  output data_t m_tdata,
  output logic  m_tlast,
  output pid_t  m_tid
);

  typedef enum logic {ST_IDLE, ST_MUX} state_t;

  state_t state_q;
  state_t state_d;

  // Beats left and owner of the current transfer
  len_t cnt_q;
  len_t cnt_d;
  pid_t pid_q;
  pid_t pid_d;

  logic beat;
  logic tr_done;

  // --------------------
  // Mux
  // --------------------
  assign m_tdata  = s_tdata;
  assign m_tlast  = s_tlast;
  assign m_tid    = pid_q;
  assign m_tvalid = (state_q == ST_MUX) ? s_tvalid : 1'b0;
  assign s_tready = (state_q == ST_MUX) ? m_tready : 1'b0;

  assign beat    = s_tvalid & s_tready;
  assign tr_done = (cnt_q == '0) && beat;

  // --------------------
  // Next state and datapath
  // --------------------
  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    pid_d      = pid_q;
    meta_ready = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (meta_valid) begin
          meta_ready = 1'b1;
          pid_d      = meta_pid;
          cnt_d      = meta_len;
          state_d    = ST_MUX;
        end
      end
      ST_MUX: begin
        if (tr_done) begin
          // Chain straight into the next queued read
          if (meta_valid) begin
            meta_ready = 1'b1;
            pid_d      = meta_pid;
            cnt_d      = meta_len;
          end else begin
            state_d = ST_IDLE;
          end
        end else if (beat) begin
          cnt_d = cnt_q - 1'b1;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Owner id, loaded before first use
  always_ff @(posedge aclk) begin
    pid_q <= pid_d;
  end

endmodule

// ==== card_mem/card_mem_reader.sv ====
// --------------------
// Card memory with a single-cycle write strobe and a streaming read engine
// Busy from the command edge until the last beat is accepted
// First beat is valid two cycles after the command, then one beat per cycle
// Addresses wrap at the top of the array
// --------------------
`timescale 1ns/1ps

module card_mem_reader import card_rd_pkg::*; (
  input  logic  aclk,
  input  logic  aresetn,

  // Write strobe, no back-pressure
  input  logic  mem_wr_en,
  input  addr_t mem_wr_addr,
  input  data_t mem_wr_data,

  // Read command
  input  logic  cmd_valid,
  output logic  cmd_ready,
  input  addr_t cmd_addr,
  input  len_t  cmd_len,

  // Beat stream
  output logic  m_tvalid,
  input  logic  m_tready,
  output data_t m_tdata,
  output logic  m_tlast
);

  typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_STREAM} state_t;

  state_t state_q;
  state_t state_d;

  // Array, no reset
  data_t mem [2**ADDR_BITS];

  // Next word address and registered read data
  addr_t addr_q;
  data_t rdata_q;

  // Beats left after the current one
  len_t cnt_q;

  logic cmd_acc;
  logic beat_acc;
  logic rd_en;

  assign cmd_acc  = cmd_valid & cmd_ready;
  assign beat_acc = m_tvalid & m_tready;

  // First word in READ, later words as each beat leaves
  assign rd_en = (state_q == ST_READ) || (beat_acc && cnt_q != '0);

  assign m_tvalid = (state_q == ST_STREAM);
  assign m_tdata  = rdata_q;
  assign m_tlast  = (state_q == ST_STREAM) && (cnt_q == '0);

  // --------------------
  // Memory
  // --------------------
  always_ff @(posedge aclk) begin
    if (mem_wr_en) begin
      mem[mem_wr_addr] <= mem_wr_data;
    end
    if (rd_en) begin
      rdata_q <= mem[addr_q];
    end
  end

  // --------------------
  // Read engine
  // --------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:   state_d = cmd_acc ? ST_READ : ST_IDLE;
      ST_READ:   state_d = ST_STREAM;
      ST_STREAM: state_d = (beat_acc && cnt_q == '0) ? ST_IDLE : ST_STREAM;
      default:   state_d = ST_IDLE;
    endcase
  end

  // cmd_ready stays low through reset, rises once idle
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q   <= ST_IDLE;
      cmd_ready <= 1'b0;
      cnt_q     <= '0;
    end else begin
      state_q   <= state_d;
      cmd_ready <= (state_d == ST_IDLE);
      if (cmd_acc) begin
        cnt_q <= cmd_len;
      end else if (beat_acc && cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Address walks with each read, wraps by width
  always_ff @(posedge aclk) begin
    if (cmd_acc) begin
      addr_q <= cmd_addr;
    end else if (rd_en) begin
      addr_q <= addr_q + 1'b1;
    end
  end

endmodule

// ==== design/mux_fifo.sv ====
// --------------------
// Metadata queue between arbiter and assigner
// One entry per granted read, holding process id and length
// Entry shows at the output one cycle after the push
// Push while full is dropped, the arbiter never does it
// --------------------
`timescale 1ns/1ps

module mux_fifo import card_rd_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic aclk,
  input  logic aresetn,

  // Write side
  input  logic push,
  input  pid_t push_pid,
  input  len_t push_len,
  output logic full,

  // Read side
  output logic out_valid,
  input  logic out_ready,
  output pid_t out_pid,
  output len_t out_len
);

  localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_BITS-1:0] PTR_LAST = PTR_BITS'(FIFO_DEPTH - 1);
  localparam logic [CNT_BITS-1:0] CNT_FULL = CNT_BITS'(FIFO_DEPTH);

  // Storage
  pid_t pid_mem [FIFO_DEPTH];
  len_t len_mem [FIFO_DEPTH];

  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [CNT_BITS-1:0] count_q;

  logic do_push;
  logic do_pop;

  assign full      = (count_q == CNT_FULL);
  assign out_valid = (count_q != '0);
  assign out_pid   = pid_mem[rd_ptr_q];
  assign out_len   = len_mem[rd_ptr_q];

  assign do_push = push & ~full;
  assign do_pop  = out_valid & out_ready;

  // Entry write
  always_ff @(posedge aclk) begin
    if (do_push) begin
      pid_mem[wr_ptr_q] <= push_pid;
      len_mem[wr_ptr_q] <= push_len;
    end
  end

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== design/rd_arbiter.sv ====
// --------------------
// Round-robin arbiter for user read requests
// Grants only when the reader takes a command and the metadata FIFO has room
// Reader command and metadata push happen on the same grant cycle
// N_REQ from 1 to 4, bounded by PID_BITS
// --------------------
`timescale 1ns/1ps

module rd_arbiter import card_rd_pkg::*; #(
  parameter int N_REQ = 4
) (
  input  logic                   aclk,
  input  logic                   aresetn,

  // Requester side
  input  logic       [N_REQ-1:0] req_valid,
  output logic       [N_REQ-1:0] req_ready,
  input  addr_t      [N_REQ-1:0] req_addr,
  input  len_t       [N_REQ-1:0] req_len,

  // Reader command
  output logic                   cmd_valid,
  input  logic                   cmd_ready,
  output addr_t                  cmd_addr,
  output len_t                   cmd_len,

  // Metadata push to the mux FIFO
  output logic                   meta_push,
  output pid_t                   meta_pid,
  output len_t                   meta_len,
  input  logic                   meta_full
);

  // Index with the highest priority this cycle
  pid_t ptr_q;

  // Selected requester
  pid_t sel;
  logic any_valid;
  logic grant;

  // --------------------
  // Select
  // --------------------

  // Scan from the far end so the closest index to ptr_q wins
  always_comb begin
    int idx;
    sel = ptr_q;
    any_valid = 1'b0;
    for (int i = N_REQ - 1; i >= 0; i--) begin
      idx = int'(ptr_q) + i;
      if (idx >= N_REQ) begin
        idx = idx - N_REQ;
      end
      if (req_valid[idx]) begin
        sel = pid_t'(idx);
        any_valid = 1'b1;
      end
    end
  end

  // Hold off when the metadata queue cannot take the entry
  assign cmd_valid = any_valid & ~meta_full;
  assign grant     = cmd_valid & cmd_ready;

  assign cmd_addr  = req_addr[sel];
  assign cmd_len   = req_len[sel];

  // Metadata follows the command on the same edge
  assign meta_push = grant;
  assign meta_pid  = sel;
  assign meta_len  = req_len[sel];

  // One-hot ready, only the granted requester
  always_comb begin
    for (int i = 0; i < N_REQ; i++) begin
      req_ready[i] = grant && (sel == pid_t'(i));
    end
  end

  // --------------------
  // Pointer
  // --------------------

  // Move past the granted index
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ptr_q <= '0;
    end else if (grant) begin
      ptr_q <= (sel == pid_t'(N_REQ - 1)) ? '0 : sel + 1'b1;
    end
  end

endmodule

// ==== common/card_rd_pkg.sv ====
// --------------------
// Shared widths and vector types for the card memory read path
// A length is stored as beats minus one, so one request moves 1 to 16 beats
// PID_BITS caps the design at four requesters
// Every beat is full width, there are no byte enables
// --------------------
package card_rd_pkg;

  // --------------------
  // Widths
  // --------------------

  // One beat of card data
  localparam int DATA_BITS = 32;

  // Word address into card memory
  localparam int ADDR_BITS = 8;

  // Beat count minus one
  localparam int LEN_BITS = 4;

  // Requester or process index
  localparam int PID_BITS = 2;

  // --------------------
  // Types
  // --------------------

  // Card data beat
  typedef logic [DATA_BITS-1:0] data_t;

  // Word address, wraps at the top of the array
  typedef logic [ADDR_BITS-1:0] addr_t;

  // Beats minus one, 0 means a single beat
  typedef logic [LEN_BITS-1:0] len_t;

  // Process id carried on tid
  typedef logic [PID_BITS-1:0] pid_t;

endpackage
